// ==== soc_top.f ====
+incdir+common
common/soc_pkg.sv
hdl/wb_addr_decoder.sv
mem/wb_bootrom.sv
mem/wb_sram.sv
hdl/clint_timer.sv
hdl/debug_req_gate.sv
hdl/soc_top.sv
verif/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the soc_top testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f soc_top.f \
  --top-module soc_tb -o soc_tb_sim \
  && ./obj_dir/soc_tb_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== verif/soc_tb.sv ====
/*
  Testbench for soc_top. Drives the Wishbone master port on the falling edge
  and checks boot ROM, SRAM byte selects, error responses, CLINT and debug gate.
  SRAM checks touch only words that were first written in full.
*/
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module soc_tb import soc_pkg::*; ();

  // About 500 cycles of tests, limit leaves a wide margin
  localparam int          MAX_CYCLES = 4000;
  localparam int          ACK_LIMIT  = 16;
  localparam int          RAM_SLOTS  = 16;
  localparam int          RAM_WRITES = 40;
  localparam int          RTC_EDGES  = 5;
  localparam logic [31:0] GPIO_ADDR  = 32'h4000_0000;

  logic        clk_i;
  logic        rst_ni;
  logic        rtc_i;
  logic        debug_req_i;
  logic        debug_en_i;
  logic        debug_req_o;
  logic        timer_irq_o;
  logic        ipi_o;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  integer      seed = 32'hae59;
  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int          cycle_cnt;
  int          rel_cnt;
  logic [63:0] ram_model [RAM_SLOTS];

  soc_top i_dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .wb_req_i    ( wb_req      ),
    .wb_rsp_o    ( wb_rsp      ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input logic exp_ack, input logic exp_err,
                           input logic ack, input logic err);
    check_val({name, " ack"}, 64'(exp_ack), 64'(ack));
    check_val({name, " err"}, 64'(exp_err), 64'(err));
  endtask

  // Posedges since reset release, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rel_cnt <= 0;
    end else if (rel_cnt < 1000) begin
      rel_cnt <= rel_cnt + 1;
    end
  end

  a_debug_gate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o == ((rel_cnt >= `DEBUG_DELAY_CYCLES) && debug_en_i && debug_req_i))
    else begin
      mismatch_cnt++;
      $display("mismatch debug gate: expected %b, actual %b",
               $sampled((rel_cnt >= `DEBUG_DELAY_CYCLES) && debug_en_i && debug_req_i),
               $sampled(debug_req_o));
    end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_rsp.ack && wb_rsp.err))
    else begin
      other_cnt++;
      $display("ack and err were high together on the master port");
    end

  a_err_zero_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp.err |-> (wb_rsp.dat == '0))
    else begin
      other_cnt++;
      $display("an error response carried nonzero data");
    end

  // ----------------------------------------
  // Bus and stimulus tasks
  // ----------------------------------------
  task automatic bus_xfer(input logic we, input logic [31:0] adr, input logic [7:0] sel,
                          input logic [63:0] wdat, output logic [63:0] rdat,
                          output logic ack, output logic err);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.sel = sel;
    wb_req.dat = wdat;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!wb_rsp.ack && !wb_rsp.err && waited < ACK_LIMIT);
    ack  = wb_rsp.ack;
    err  = wb_rsp.err;
    rdat = wb_rsp.dat;
    if (!ack && !err) begin
      other_cnt++;
      $display("no ack or err within %0d cycles at address %h", ACK_LIMIT, adr);
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] adr, output logic [63:0] data,
                           output logic ack, output logic err);
    bus_xfer(1'b0, adr, 8'hff, '0, data, ack, err);
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [7:0] sel,
                            input logic [63:0] data, output logic ack, output logic err);
    logic [63:0] unused;
    bus_xfer(1'b1, adr, sel, data, unused, ack, err);
  endtask

  // Starts on a falling edge, 4 cycles high, 4 cycles low
  task automatic rtc_pulse();
    rtc_i = 1'b1;
    repeat (4) @(negedge clk_i);
    rtc_i = 1'b0;
    repeat (4) @(negedge clk_i);
  endtask

  function automatic logic [63:0] sel_mask(input logic [7:0] sel);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{sel[b]}};
    end
    return mask;
  endfunction

  function automatic logic [31:0] slot_addr(input int slot);
    return `RAM_BASE + 32'(slot * 17 * 8);
  endfunction

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [63:0] rd;
    logic [63:0] wd;
    logic [63:0] mask;
    logic [7:0]  sel;
    logic        ack;
    logic        err;
    int          slot;
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    wb_req      = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    // Boot ROM contents
    for (int k = 0; k < `ROM_WORDS; k++) begin
      read_word(`ROM_BASE + 32'(8 * k), rd, ack, err);
      check_rsp("rom read", 1'b1, 1'b0, ack, err);
      check_val("rom read data", `ROM_SIGNATURE ^ 64'(k), rd);
    end

    // SRAM, full writes first so the model is defined everywhere
    for (int s = 0; s < RAM_SLOTS; s++) begin
      wd = {$random(seed), $random(seed)};
      ram_model[s] = wd;
      write_word(slot_addr(s), 8'hff, wd, ack, err);
      check_rsp("ram init write", 1'b1, 1'b0, ack, err);
    end
    for (int i = 0; i < RAM_WRITES; i++) begin
      slot = $unsigned($random(seed)) % RAM_SLOTS;
      sel  = 8'($random(seed));
      wd   = {$random(seed), $random(seed)};
      mask = sel_mask(sel);
      ram_model[slot] = (ram_model[slot] & ~mask) | (wd & mask);
      write_word(slot_addr(slot), sel, wd, ack, err);
      check_rsp("ram byte write", 1'b1, 1'b0, ack, err);
      read_word(slot_addr(slot), rd, ack, err);
      check_val("ram byte readback", ram_model[slot], rd);
    end
    for (int s = 0; s < RAM_SLOTS; s++) begin
      read_word(slot_addr(s), rd, ack, err);
      check_rsp("ram final read", 1'b1, 1'b0, ack, err);
      check_val("ram final data", ram_model[s], rd);
    end

    // Error responses
    read_word(GPIO_ADDR, rd, ack, err);
    check_rsp("gpio read", 1'b0, 1'b1, ack, err);
    check_val("gpio read data", 64'h0, rd);
    write_word(`ROM_BASE + 32'h10, 8'hff, 64'h1234, ack, err);
    check_rsp("rom write", 1'b0, 1'b1, ack, err);
    read_word(`ROM_BASE + 32'h28, rd, ack, err);
    check_rsp("read after err", 1'b1, 1'b0, ack, err);
    check_val("read after err data", `ROM_SIGNATURE ^ 64'd5, rd);

    // Timer and compare interrupt
    repeat (RTC_EDGES) rtc_pulse();
    read_word(`CLINT_BASE + `CLINT_MTIME_OFS, rd, ack, err);
    check_rsp("mtime read", 1'b1, 1'b0, ack, err);
    check_val("mtime count", 64'(RTC_EDGES), rd);
    write_word(`CLINT_BASE + `CLINT_MTIMECMP_OFS, 8'hff, 64'(RTC_EDGES + 2), ack, err);
    check_rsp("mtimecmp write", 1'b1, 1'b0, ack, err);
    repeat (2) @(negedge clk_i);
    check_val("irq below compare", 64'h0, 64'(timer_irq_o));
    rtc_pulse();
    check_val("irq one edge short", 64'h0, 64'(timer_irq_o));
    // Last edge, irq due 4 cycles later after sync, count and compare
    rtc_i = 1'b1;
    repeat (3) @(negedge clk_i);
    check_val("irq during rtc sync", 64'h0, 64'(timer_irq_o));
    @(negedge clk_i);
    check_val("irq at compare", 64'h1, 64'(timer_irq_o));
    rtc_i = 1'b0;
    repeat (4) @(negedge clk_i);

    // Software interrupt
    write_word(`CLINT_BASE + `CLINT_MSIP_OFS, 8'hff, 64'h1, ack, err);
    @(negedge clk_i);
    check_val("ipi set", 64'h1, 64'(ipi_o));
    read_word(`CLINT_BASE + `CLINT_MSIP_OFS, rd, ack, err);
    check_val("msip read one", 64'h1, rd);
    write_word(`CLINT_BASE + `CLINT_MSIP_OFS, 8'hff, 64'h0, ack, err);
    @(negedge clk_i);
    check_val("ipi clear", 64'h0, 64'(ipi_o));
    read_word(`CLINT_BASE + `CLINT_MSIP_OFS, rd, ack, err);
    check_val("msip read zero", 64'h0, rd);

    // Debug gate with enable dropped, then restored
    debug_en_i = 1'b0;
    repeat (4) @(negedge clk_i);
    check_val("debug disabled", 64'h0, 64'(debug_req_o));
    debug_en_i = 1'b1;
    @(negedge clk_i);
    check_val("debug enabled", 64'h1, 64'(debug_req_o));

    repeat (4) @(negedge clk_i);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/soc_top.sv ====
/*
  SoC memory fabric top: one Wishbone master port, boot ROM, SRAM, CLINT
  and the debug request gate. Unmapped accesses end in err.
*/
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module soc_top import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    rtc_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output logic    timer_irq_o,
  output logic    ipi_o,
  input  logic    debug_req_i,
  input  logic    debug_en_i,
  output logic    debug_req_o
);

  wb_req_t rom_req, ram_req, clint_req;
  wb_rsp_t rom_rsp, ram_rsp, clint_rsp;

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  wb_addr_decoder i_decoder (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .m_req_i     ( wb_req_i  ),
    .m_rsp_o     ( wb_rsp_o  ),
    .rom_req_o   ( rom_req   ),
    .ram_req_o   ( ram_req   ),
    .clint_req_o ( clint_req ),
    .rom_rsp_i   ( rom_rsp   ),
    .ram_rsp_i   ( ram_rsp   ),
    .clint_rsp_i ( clint_rsp )
  );

  // ----------------------------------------
  // Memories
  // ----------------------------------------
  wb_bootrom i_bootrom (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( rom_req ),
    .rsp_o  ( rom_rsp )
  );

  wb_sram #(
    .NUM_WORDS ( `RAM_WORDS )
  ) i_sram (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( ram_req ),
    .rsp_o  ( ram_rsp )
  );

  // ----------------------------------------
  // Timer, interrupts and debug
  // ----------------------------------------
  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

// ==== hdl/debug_req_gate.sv ====
/*
  Holds off the debug request for a fixed number of cycles after reset,
  then passes it only while debug is enabled. Output is combinational.
*/
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int CNT_W = $clog2(`DEBUG_DELAY_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             cnt_done;

  assign cnt_done = (cnt_q == '0);

  // Counts down once after reset, then parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CNT_W'(`DEBUG_DELAY_CYCLES);
    end else if (!cnt_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = cnt_done & debug_en_i & debug_req_i;

endmodule

`default_nettype wire

// ==== hdl/clint_timer.sv ====
/*
  Single-hart CLINT with msip, mtimecmp and mtime, all 64-bit accessible.
  rtc_i must be much slower than clk_i; edges closer than 3 cycles are lost.
  Offsets other than the three registers get err.
*/
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module clint_timer import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    rtc_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o,
  output logic    timer_irq_o,
  output logic    ipi_o
);

  logic [`SOC_ADDR_W-1:0] ofs;
  logic                   hit_msip, hit_cmp, hit_time, hit;
  logic                   access, wr;
  logic [2:0]             rtc_q;
  logic                   rtc_edge;
  logic [63:0]            mtime_q, mtimecmp_q, mtime_inc;
  logic                   msip_q;
  logic                   irq_q, ack_q, err_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  assign ofs      = req_i.adr - `CLINT_BASE;
  assign hit_msip = (ofs == `CLINT_MSIP_OFS);
  assign hit_cmp  = (ofs == `CLINT_MTIMECMP_OFS);
  assign hit_time = (ofs == `CLINT_MTIME_OFS);
  assign hit      = hit_msip | hit_cmp | hit_time;
  assign access   = req_i.cyc & req_i.stb & ~(ack_q | err_q);
  assign wr       = access & req_i.we;

  // Two sync flops, third one for edge detect
  assign rtc_edge  = rtc_q[1] & ~rtc_q[2];
  assign mtime_inc = mtime_q + 64'(rtc_edge);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      irq_q      <= 1'b0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      rtc_q   <= {rtc_q[1:0], rtc_i};
      irq_q   <= (mtime_q >= mtimecmp_q);
      ack_q   <= access & hit;
      err_q   <= access & ~hit;
      // A bus write wins over the tick on the bytes it selects
      mtime_q <= (wr && hit_time) ? byte_merge(mtime_inc, req_i.dat, req_i.sel) : mtime_inc;
      if (wr && hit_cmp) mtimecmp_q <= byte_merge(mtimecmp_q, req_i.dat, req_i.sel);
      if (wr && hit_msip && req_i.sel[0]) msip_q <= req_i.dat[0];
    end
  end

  // Read mux, err returns zero
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (hit_time)      rdata_q <= mtime_q;
      else if (hit_cmp)  rdata_q <= mtimecmp_q;
      else if (hit_msip) rdata_q <= `SOC_DATA_W'(msip_q);
      else               rdata_q <= '0;
    end
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = err_q;
  assign rsp_o.dat   = rdata_q;
  assign timer_irq_o = irq_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// ==== mem/wb_sram.sv ====
/*
  Single-port SRAM with byte selects, one-cycle read and write latency.
  Contents are undefined after power-up; reset does not clear them.
*/
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module wb_sram import soc_pkg::*; #(
  parameter int NUM_WORDS = `RAM_WORDS
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int OFS_W = $clog2(`SOC_SEL_W);
  localparam int IDX_W = $clog2(NUM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [NUM_WORDS];

  logic [IDX_W-1:0]       idx;
  logic                   access;
  logic                   ack_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  // Word index taken above the byte offset
  assign idx    = req_i.adr[OFS_W +: IDX_W];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      mem[idx] <= byte_merge(mem[idx], req_i.dat, req_i.sel);
    end
  end

  // Old contents on a write, only read data matters to the master
  always_ff @(posedge clk_i) begin
    if (access) rdata_q <= mem[idx];
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rdata_q;

  // Decoder must never steer an access past the end of the array
  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.cyc && req_i.stb) |-> (((req_i.adr - `RAM_BASE) >> OFS_W) < NUM_WORDS));

endmodule

`default_nettype wire

// ==== mem/wb_bootrom.sv ====
/*
  Read-only boot ROM, word k holds the signature XOR k.
  Writes are answered with err and zero data.
*/
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module wb_bootrom import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int OFS_W = $clog2(`SOC_SEL_W);
  localparam int IDX_W = $clog2(`ROM_WORDS);

  logic [IDX_W-1:0]       idx;
  logic                   access;
  logic                   ack_q;
  logic                   err_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  function automatic logic [`SOC_DATA_W-1:0] rom_word(input logic [IDX_W-1:0] k);
    return `ROM_SIGNATURE ^ `SOC_DATA_W'(k);
  endfunction

  assign idx    = req_i.adr[OFS_W +: IDX_W];
  // No new answer while the previous one is on the bus
  assign access = req_i.cyc & req_i.stb & ~(ack_q | err_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access & ~req_i.we;
      err_q <= access & req_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) rdata_q <= req_i.we ? '0 : rom_word(idx);
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = err_q;
  assign rsp_o.dat = rdata_q;

  // Only a request that the decoder steered into the ROM window gets an ack
  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.ack |-> $past(req_i.cyc && req_i.stb &&
                        ((req_i.adr - `ROM_BASE) < `ROM_WORDS * `SOC_SEL_W)));

endmodule

`default_nettype wire

// ==== hdl/wb_addr_decoder.sv ====
/*
  Single-master Wishbone decoder for ROM, RAM and CLINT windows.
  Unmapped addresses (GPIO included) get an err one cycle after stb.
  The response select is registered with the request, so adr may move after ack.
*/
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module wb_addr_decoder import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t m_req_i,
  output wb_rsp_t m_rsp_o,
  output wb_req_t rom_req_o,
  output wb_req_t ram_req_o,
  output wb_req_t clint_req_o,
  input  wb_rsp_t rom_rsp_i,
  input  wb_rsp_t ram_rsp_i,
  input  wb_rsp_t clint_rsp_i
);

  localparam logic [`SOC_ADDR_W-1:0] ROM_END   = `ROM_BASE + `ROM_WORDS * `SOC_SEL_W;
  localparam logic [`SOC_ADDR_W-1:0] RAM_END   = `RAM_BASE + `RAM_WORDS * `SOC_SEL_W;
  localparam logic [`SOC_ADDR_W-1:0] CLINT_END = `CLINT_BASE + `CLINT_SIZE;

  target_e tgt;
  target_e tgt_q;
  logic    req_vld;
  logic    err_q;

  assign req_vld = m_req_i.cyc & m_req_i.stb;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  always_comb begin
    if (m_req_i.adr >= `ROM_BASE && m_req_i.adr < ROM_END) begin
      tgt = TGT_ROM;
    end else if (m_req_i.adr >= `RAM_BASE && m_req_i.adr < RAM_END) begin
      tgt = TGT_RAM;
    end else if (m_req_i.adr >= `CLINT_BASE && m_req_i.adr < CLINT_END) begin
      tgt = TGT_CLINT;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // Request copied to every target, stb only where selected
  always_comb begin
    rom_req_o       = m_req_i;
    ram_req_o       = m_req_i;
    clint_req_o     = m_req_i;
    rom_req_o.stb   = m_req_i.stb & (tgt == TGT_ROM);
    ram_req_o.stb   = m_req_i.stb & (tgt == TGT_RAM);
    clint_req_o.stb = m_req_i.stb & (tgt == TGT_CLINT);
  end

  // Select follows the request that the responding target saw
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q <= TGT_NONE;
      err_q <= 1'b0;
    end else begin
      if (req_vld) tgt_q <= tgt;
      err_q <= req_vld & (tgt == TGT_NONE) & ~err_q;
    end
  end

  // ----------------------------------------
  // Response mux
  // ----------------------------------------
  always_comb begin
    unique case (tgt_q)
      TGT_ROM:   m_rsp_o = rom_rsp_i;
      TGT_RAM:   m_rsp_o = ram_rsp_i;
      TGT_CLINT: m_rsp_o = clint_rsp_i;
      default: begin
        m_rsp_o.ack = 1'b0;
        m_rsp_o.err = err_q;
        m_rsp_o.dat = '0;
      end
    endcase
  end

  // Holds across every target and the local error path
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(m_rsp_o.ack && m_rsp_o.err));

endmodule

`default_nettype wire

// ==== common/soc_pkg.sv ====
/*
  Wishbone classic request and response structs plus the decode result.
  Needs soc_macros.svh on the include path.
*/
`default_nettype none

`include "soc_macros.svh"

package soc_pkg;

  // Master to slave, held stable until ack or err
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] adr;
    logic [`SOC_SEL_W-1:0]  sel;
    logic [`SOC_DATA_W-1:0] dat;
  } wb_req_t;

  // Slave to master, ack and err are one-cycle pulses
  typedef struct packed {
    logic                   ack;
    logic                   err;
    logic [`SOC_DATA_W-1:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_RAM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

  // Replace the bytes of old_v whose select bit is set
  function automatic logic [`SOC_DATA_W-1:0] byte_merge(
    input logic [`SOC_DATA_W-1:0] old_v,
    input logic [`SOC_DATA_W-1:0] new_v,
    input logic [`SOC_SEL_W-1:0]  sel
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < `SOC_SEL_W; b++) begin
      if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== common/soc_macros.svh ====
/*
  Bus widths, memory map and timing constants for the SoC fabric.
  Windows must be aligned to their size; the decoder does no wrap checks.
*/
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Wishbone bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_SEL_W  8

// Boot ROM, contents derived from the signature
`define ROM_BASE      32'h0001_0000
`define ROM_WORDS     32
`define ROM_SIGNATURE 64'hB007_C0DE_5EED_F00D

// Main SRAM
`define RAM_BASE  32'h8000_0000
`define RAM_WORDS 256

// CLINT window and register offsets
`define CLINT_BASE         32'h0200_0000
`define CLINT_MSIP_OFS     32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS    32'h0000_BFF8
`define CLINT_SIZE         32'h0000_C000

// Debug request hold-off after reset, in clk_i cycles
`define DEBUG_DELAY_CYCLES 20

`endif
